// ==== hw/dekoderPkg.sv ====
package dekoderPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int wortBreite = 32;
    localparam int adrBreite = 16;
    // bit 5 of an index selects the float bank.
    localparam int regIndexBreite = 6;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcodes, instruction bits 31:26
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [5:0] opLadeInt = 6'b101010;
    localparam logic [5:0] opLadeFloat = 6'b101011;
    localparam logic [5:0] opSpeichere = 6'b101100;
    localparam logic [5:0] opSprungAbs = 6'b101101;
    localparam logic [5:0] opSprungBed = 6'b101110;
    localparam logic [5:0] opJal = 6'b101111;
    localparam logic [5:0] opSprungRel = 6'b010000;

    typedef struct packed {
        logic [regIndexBreite-1:0] quellRegister1;
        logic [regIndexBreite-1:0] quellRegister2;
        logic [regIndexBreite-1:0] zielRegister;
        logic [25:0] iDaten;
        logic [5:0] funktionsCode;
        logic kleinerImmediate;
        logic grosserImmediate;
        logic jal;
        logic relativerSprung;
        logic absoluterSprung;
        logic float;
        logic load;
        logic store;
        logic unbedingterSprung;
        logic bedingterSprung;
    } dekodiertT;

endpackage

// ==== hw/memAnfrageIf.sv ====
`timescale 1ns/1ps

interface memAnfrageIf;

    logic anfrage;
    logic schreiben;
    logic [dekoderPkg::adrBreite-1:0] adresse;
    logic [dekoderPkg::wortBreite-1:0] schreibDaten;
    logic zuteilung;
    logic [dekoderPkg::wortBreite-1:0] leseDaten;
    // one cycle after a granted read.
    logic leseGueltig;

    modport anfrager (
        output anfrage, schreiben, adresse, schreibDaten,
        input  zuteilung, leseDaten, leseGueltig
    );

    modport arbiter (
        input  anfrage, schreiben, adresse, schreibDaten,
        output zuteilung, leseDaten, leseGueltig
    );

endinterface

// ==== hw/instruktionsDekodierer.sv ====
`timescale 1ns/1ps

module instruktionsDekodierer (
    input  logic DekodierSignal,
    input  logic arstN,
    input  logic uebernehmen,
    input  logic [dekoderPkg::wortBreite-1:0] instruktion,
    output dekoderPkg::dekodiertT dekodiert
);

    logic [dekoderPkg::wortBreite-1:0] befehlReg;
    logic [5:0] op;
    logic registerFormat;
    logic floatReg;

    // zero decodes as a register-format no-op.
    always_ff @(posedge DekodierSignal or negedge arstN) begin
        if (!arstN) begin
            befehlReg <= '0;
        end else if (uebernehmen) begin
            befehlReg <= instruktion;
        end
    end

    assign op = befehlReg[31:26];
    assign registerFormat = befehlReg[31:30] == 2'b00;
    // funct 10xxxx marks a float register operation.
    assign floatReg = registerFormat && befehlReg[5:4] == 2'b10;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        dekodiert = '0;
        if (registerFormat) begin
            dekodiert.quellRegister1 = {floatReg, befehlReg[20:16]};
            dekodiert.quellRegister2 = {floatReg, befehlReg[15:11]};
            dekodiert.zielRegister = {floatReg, befehlReg[25:21]};
            dekodiert.funktionsCode = befehlReg[5:0];
        end else if (befehlReg[31]) begin
            dekodiert.kleinerImmediate = 1'b1;
            dekodiert.quellRegister1 = {1'b0, befehlReg[20:16]};
            dekodiert.zielRegister = {op == dekoderPkg::opLadeFloat, befehlReg[25:21]};
            dekodiert.iDaten = {{10{befehlReg[15]}}, befehlReg[15:0]};
            // store data register sits in the destination field.
            if (op == dekoderPkg::opSpeichere) begin
                dekodiert.quellRegister2 = {1'b0, befehlReg[25:21]};
            end
            if (!(op inside {[dekoderPkg::opLadeInt:dekoderPkg::opJal]})) begin
                dekodiert.funktionsCode = {1'b0, befehlReg[30:26]};
            end
        end else begin
            dekodiert.grosserImmediate = 1'b1;
            dekodiert.iDaten = befehlReg[25:0];
        end

        dekodiert.jal = op == dekoderPkg::opJal;
        dekodiert.relativerSprung = op == dekoderPkg::opJal || op == dekoderPkg::opSprungRel
            || op == dekoderPkg::opSprungBed;
        dekodiert.absoluterSprung = op == dekoderPkg::opSprungAbs;
        dekodiert.float = floatReg || op == dekoderPkg::opLadeFloat;
        dekodiert.load = op == dekoderPkg::opLadeInt || op == dekoderPkg::opLadeFloat;
        dekodiert.store = op == dekoderPkg::opSpeichere;
        dekodiert.unbedingterSprung = op == dekoderPkg::opSprungAbs
            || op == dekoderPkg::opJal || op == dekoderPkg::opSprungRel;
        dekodiert.bedingterSprung = op == dekoderPkg::opSprungBed;
    end

endmodule

// ==== hw/befehlsHoler.sv ====
`timescale 1ns/1ps

module befehlsHoler (
    input  logic DekodierSignal,
    input  logic arstN,
    memAnfrageIf.anfrager speicher,
    input  logic umleiten,
    input  logic [dekoderPkg::adrBreite-1:0] zielPc,
    input  logic weiter,
    output logic befehlBereit,
    output logic [dekoderPkg::wortBreite-1:0] befehl,
    output logic [dekoderPkg::adrBreite-1:0] befehlPc
);

    logic [dekoderPkg::adrBreite-1:0] pc;
    logic ausstehend;

    // next word goes out as soon as the buffer is being emptied.
    assign speicher.anfrage = !ausstehend && (!befehlBereit || weiter) && !umleiten;
    assign speicher.schreiben = 1'b0;
    assign speicher.adresse = pc;
    assign speicher.schreibDaten = '0;
    // pc has already moved past the buffered word.
    assign befehlPc = pc - 1'b1;

    always_ff @(posedge DekodierSignal or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
            ausstehend <= 1'b0;
            befehlBereit <= 1'b0;
        end else if (umleiten) begin
            // a reply arriving now is stale and dropped.
            pc <= zielPc;
            ausstehend <= 1'b0;
            befehlBereit <= 1'b0;
        end else begin
            ausstehend <= speicher.anfrage && speicher.zuteilung;
            if (speicher.anfrage && speicher.zuteilung) begin
                pc <= pc + 1'b1;
            end
            if (speicher.leseGueltig) begin
                befehlBereit <= 1'b1;
            end else if (weiter) begin
                befehlBereit <= 1'b0;
            end
        end
    end

    always_ff @(posedge DekodierSignal) begin
        if (speicher.leseGueltig) begin
            befehl <= speicher.leseDaten;
        end
    end

endmodule

// ==== hw/ladeSpeicherEinheit.sv ====
`timescale 1ns/1ps

module ladeSpeicherEinheit (
    input  logic DekodierSignal,
    input  logic arstN,
    memAnfrageIf.anfrager speicher,
    input  logic start,
    input  logic istStore,
    input  logic [dekoderPkg::wortBreite-1:0] basis,
    input  logic [25:0] versatz,
    input  logic [dekoderPkg::wortBreite-1:0] storeDaten,
    output logic fertig,
    output logic [dekoderPkg::wortBreite-1:0] ladeDaten
);

    logic aktiv;
    logic schreibenReg;
    logic [dekoderPkg::adrBreite-1:0] adresseReg;
    logic [dekoderPkg::wortBreite-1:0] datenReg;

    assign speicher.anfrage = aktiv;
    assign speicher.schreiben = schreibenReg;
    assign speicher.adresse = adresseReg;
    assign speicher.schreibDaten = datenReg;

    // a store is done on its grant, a load on its reply.
    assign fertig = (aktiv && schreibenReg && speicher.zuteilung) || speicher.leseGueltig;
    assign ladeDaten = speicher.leseDaten;

    always_ff @(posedge DekodierSignal or negedge arstN) begin
        if (!arstN) begin
            aktiv <= 1'b0;
        end else if (start) begin
            aktiv <= 1'b1;
        end else if (speicher.zuteilung) begin
            aktiv <= 1'b0;
        end
    end

    // word address wraps at adrBreite bits.
    always_ff @(posedge DekodierSignal) begin
        if (start) begin
            schreibenReg <= istStore;
            adresseReg <= basis[dekoderPkg::adrBreite-1:0]
                + versatz[dekoderPkg::adrBreite-1:0];
            datenReg <= storeDaten;
        end
    end

endmodule

// ==== hw/speicherArbiter.sv ====
`timescale 1ns/1ps

module speicherArbiter (
    input  logic DekodierSignal,
    input  logic arstN,
    memAnfrageIf.arbiter holer,
    memAnfrageIf.arbiter lsu,
    output logic memAnfrage,
    output logic memSchreiben,
    output logic [dekoderPkg::adrBreite-1:0] memAdresse,
    output logic [dekoderPkg::wortBreite-1:0] memSchreibDaten,
    input  logic [dekoderPkg::wortBreite-1:0] memLeseDaten,
    input  logic memLeseGueltig
);

    logic lsuBesitzer;

    // load/store unit always wins.
    assign lsu.zuteilung = lsu.anfrage;
    assign holer.zuteilung = holer.anfrage && !lsu.anfrage;

    assign memAnfrage = lsu.anfrage || holer.anfrage;
    assign memSchreiben = lsu.anfrage ? lsu.schreiben : holer.schreiben;
    assign memAdresse = lsu.anfrage ? lsu.adresse : holer.adresse;
    assign memSchreibDaten = lsu.anfrage ? lsu.schreibDaten : holer.schreibDaten;

    // owner of the read in flight.
    always_ff @(posedge DekodierSignal or negedge arstN) begin
        if (!arstN) begin
            lsuBesitzer <= 1'b0;
        end else if (memAnfrage && !memSchreiben) begin
            lsuBesitzer <= lsu.anfrage;
        end
    end

    assign lsu.leseGueltig = memLeseGueltig && lsuBesitzer;
    assign holer.leseGueltig = memLeseGueltig && !lsuBesitzer;
    assign lsu.leseDaten = memLeseDaten;
    assign holer.leseDaten = memLeseDaten;

endmodule

// ==== hw/registerBank.sv ====
`timescale 1ns/1ps

module registerBank (
    input  logic DekodierSignal,
    input  logic arstN,
    input  logic [dekoderPkg::regIndexBreite-1:0] leseIndex1,
    input  logic [dekoderPkg::regIndexBreite-1:0] leseIndex2,
    output logic [dekoderPkg::wortBreite-1:0] leseDaten1,
    output logic [dekoderPkg::wortBreite-1:0] leseDaten2,
    input  logic schreibFreigabe,
    input  logic [dekoderPkg::regIndexBreite-1:0] schreibIndex,
    input  logic [dekoderPkg::wortBreite-1:0] schreibDaten
);

    // lower 32 integer, upper 32 float.
    logic [dekoderPkg::wortBreite-1:0] registerFeld [2**dekoderPkg::regIndexBreite];

    always_ff @(posedge DekodierSignal or negedge arstN) begin
        if (!arstN) begin
            registerFeld <= '{default: '0};
        end else if (schreibFreigabe) begin
            registerFeld[schreibIndex] <= schreibDaten;
        end
    end

    assign leseDaten1 = registerFeld[leseIndex1];
    assign leseDaten2 = registerFeld[leseIndex2];

endmodule

// ==== hw/ablaufSteuerung.sv ====
`timescale 1ns/1ps

module ablaufSteuerung (
    input  logic DekodierSignal,
    input  logic arstN,
    input  logic befehlBereit,
    input  logic [dekoderPkg::adrBreite-1:0] befehlPc,
    output logic uebernehmen,
    input  dekoderPkg::dekodiertT dekodiert,
    output logic [dekoderPkg::regIndexBreite-1:0] leseIndex1,
    output logic [dekoderPkg::regIndexBreite-1:0] leseIndex2,
    input  logic [dekoderPkg::wortBreite-1:0] leseDaten1,
    input  logic [dekoderPkg::wortBreite-1:0] leseDaten2,
    output logic schreibFreigabe,
    output logic [dekoderPkg::regIndexBreite-1:0] schreibIndex,
    output logic [dekoderPkg::wortBreite-1:0] schreibDaten,
    output logic weiter,
    output logic umleiten,
    output logic [dekoderPkg::adrBreite-1:0] zielPc,
    output logic lsuStart,
    output logic lsuIstStore,
    output logic [dekoderPkg::wortBreite-1:0] lsuBasis,
    output logic [25:0] lsuVersatz,
    output logic [dekoderPkg::wortBreite-1:0] lsuStoreDaten,
    input  logic lsuFertig,
    input  logic [dekoderPkg::wortBreite-1:0] lsuLadeDaten,
    output logic retireGueltig,
    output logic [dekoderPkg::adrBreite-1:0] retirePc
);

    typedef enum logic [2:0] {
        zStart,
        zHolen,
        zDekodieren,
        zAusfuehren,
        zSpeicher,
        zRueckschreiben
    } zustandT;

    zustandT zustand;
    logic [dekoderPkg::adrBreite-1:0] pc;
    logic [dekoderPkg::wortBreite-1:0] ergebnis;
    logic sprung;

    assign leseIndex1 = dekodiert.quellRegister1;
    assign leseIndex2 = dekodiert.quellRegister2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control flow
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign sprung = dekodiert.unbedingterSprung
        || (dekodiert.bedingterSprung && leseDaten1 != '0);
    assign uebernehmen = zustand == zHolen && befehlBereit;
    assign weiter = uebernehmen;
    // start state points the fetcher at word zero.
    assign umleiten = zustand == zStart || (zustand == zAusfuehren && sprung);
    assign zielPc = (zustand == zStart) ? '0
        : dekodiert.absoluterSprung ? dekodiert.iDaten[dekoderPkg::adrBreite-1:0]
        : pc + dekodiert.iDaten[dekoderPkg::adrBreite-1:0];

    assign lsuStart = zustand == zAusfuehren && (dekodiert.load || dekodiert.store);
    assign lsuIstStore = dekodiert.store;
    assign lsuBasis = leseDaten1;
    assign lsuVersatz = dekodiert.iDaten;
    assign lsuStoreDaten = leseDaten2;

    assign schreibFreigabe = zustand == zRueckschreiben && (dekodiert.load || dekodiert.jal);
    assign schreibIndex = dekodiert.zielRegister;
    assign schreibDaten = ergebnis;
    assign retireGueltig = zustand == zRueckschreiben;
    assign retirePc = pc;

    always_ff @(posedge DekodierSignal or negedge arstN) begin
        if (!arstN) begin
            zustand <= zStart;
            pc <= '0;
        end else begin
            case (zustand)
                zStart: zustand <= zHolen;
                zHolen: begin
                    if (befehlBereit) begin
                        pc <= befehlPc;
                        zustand <= zDekodieren;
                    end
                end
                zDekodieren: zustand <= zAusfuehren;
                zAusfuehren: zustand <= lsuStart ? zSpeicher : zRueckschreiben;
                zSpeicher: begin
                    if (lsuFertig) begin
                        zustand <= zRueckschreiben;
                    end
                end
                zRueckschreiben: zustand <= zHolen;
                default: zustand <= zStart;
            endcase
        end
    end

    // link address or loaded word.
    always_ff @(posedge DekodierSignal) begin
        if (zustand == zAusfuehren) begin
            ergebnis <= {{(dekoderPkg::wortBreite - dekoderPkg::adrBreite){1'b0}}, pc + 1'b1};
        end else if (zustand == zSpeicher && lsuFertig) begin
            ergebnis <= lsuLadeDaten;
        end
    end

endmodule

// ==== hw/dekoderKern.sv ====
`timescale 1ns/1ps

module dekoderKern (
    input  logic DekodierSignal,
    input  logic arstN,
    output logic memAnfrage,
    output logic memSchreiben,
    output logic [dekoderPkg::adrBreite-1:0] memAdresse,
    output logic [dekoderPkg::wortBreite-1:0] memSchreibDaten,
    input  logic [dekoderPkg::wortBreite-1:0] memLeseDaten,
    input  logic memLeseGueltig,
    output logic retireGueltig,
    output logic [dekoderPkg::adrBreite-1:0] retirePc
);

    memAnfrageIf holerAnfrage ();
    memAnfrageIf lsuAnfrage ();

    dekoderPkg::dekodiertT dekodiert;
    logic uebernehmen;
    logic weiter;
    logic umleiten;
    logic befehlBereit;
    logic [dekoderPkg::wortBreite-1:0] befehl;
    logic [dekoderPkg::adrBreite-1:0] befehlPc;
    logic [dekoderPkg::adrBreite-1:0] zielPc;
    logic [dekoderPkg::regIndexBreite-1:0] leseIndex1;
    logic [dekoderPkg::regIndexBreite-1:0] leseIndex2;
    logic [dekoderPkg::regIndexBreite-1:0] schreibIndex;
    logic [dekoderPkg::wortBreite-1:0] leseDaten1;
    logic [dekoderPkg::wortBreite-1:0] leseDaten2;
    logic [dekoderPkg::wortBreite-1:0] schreibDaten;
    logic schreibFreigabe;
    logic lsuStart;
    logic lsuIstStore;
    logic lsuFertig;
    logic [dekoderPkg::wortBreite-1:0] lsuBasis;
    logic [25:0] lsuVersatz;
    logic [dekoderPkg::wortBreite-1:0] lsuStoreDaten;
    logic [dekoderPkg::wortBreite-1:0] lsuLadeDaten;

    befehlsHoler holer0 (
        .DekodierSignal, .arstN, .speicher(holerAnfrage.anfrager),
        .umleiten, .zielPc, .weiter, .befehlBereit, .befehl, .befehlPc
    );

    instruktionsDekodierer dekodierer0 (
        .DekodierSignal, .arstN, .uebernehmen, .instruktion(befehl), .dekodiert
    );

    ladeSpeicherEinheit lsu0 (
        .DekodierSignal, .arstN, .speicher(lsuAnfrage.anfrager),
        .start(lsuStart), .istStore(lsuIstStore), .basis(lsuBasis),
        .versatz(lsuVersatz), .storeDaten(lsuStoreDaten),
        .fertig(lsuFertig), .ladeDaten(lsuLadeDaten)
    );

    speicherArbiter arbiter0 (
        .DekodierSignal, .arstN, .holer(holerAnfrage.arbiter), .lsu(lsuAnfrage.arbiter),
        .memAnfrage, .memSchreiben, .memAdresse, .memSchreibDaten,
        .memLeseDaten, .memLeseGueltig
    );

    registerBank register0 (
        .DekodierSignal, .arstN, .leseIndex1, .leseIndex2, .leseDaten1, .leseDaten2,
        .schreibFreigabe, .schreibIndex, .schreibDaten
    );

    ablaufSteuerung steuerung0 (
        .DekodierSignal, .arstN, .befehlBereit, .befehlPc, .uebernehmen, .dekodiert,
        .leseIndex1, .leseIndex2, .leseDaten1, .leseDaten2,
        .schreibFreigabe, .schreibIndex, .schreibDaten,
        .weiter, .umleiten, .zielPc,
        .lsuStart, .lsuIstStore, .lsuBasis, .lsuVersatz, .lsuStoreDaten,
        .lsuFertig, .lsuLadeDaten, .retireGueltig, .retirePc
    );

endmodule

// ==== verif/taktGeber.sv ====
`timescale 1ns/1ps

module taktGeber (
    output logic DekodierSignal,
    output logic arstN,
    input  logic neuStart
);

    int zaehler;

    // 20 ns period.
    initial begin
        DekodierSignal = 1'b0;
        forever #10 DekodierSignal = ~DekodierSignal;
    end

    initial begin
        arstN = 1'b0;
        zaehler = 0;
    end

    // reset stays low for 16 cycles, again after each neuStart.
    always @(negedge DekodierSignal) begin
        if (neuStart) begin
            arstN <= 1'b0;
            zaehler <= 0;
        end else if (!arstN) begin
            zaehler <= zaehler + 1;
            if (zaehler == 15) begin
                arstN <= 1'b1;
            end
        end
    end

endmodule

// ==== verif/dekoderKern_props.sv ====
`timescale 1ns/1ps

module dekoderKernProps (
    input logic DekodierSignal,
    input logic arstN,
    input logic holerZuteilung,
    input logic lsuZuteilung,
    input logic holerLeseGueltig,
    input logic lsuLeseGueltig,
    input logic memAnfrage,
    input logic memSchreiben,
    input logic retireGueltig
);

    // a read in flight blocks every grant on the next cycle.
    einZuteilung: assert property (@(posedge DekodierSignal) disable iff (!arstN)
        ((holerZuteilung || lsuZuteilung) && !memSchreiben)
        |=> (!holerZuteilung && !lsuZuteilung))
        else $error("second grant while a read is in flight");

    // each reply goes to the requester granted a read one cycle earlier.
    lsuAntwort: assert property (@(posedge DekodierSignal) disable iff (!arstN)
        lsuLeseGueltig |-> $past(lsuZuteilung && !memSchreiben))
        else $error("load/store unit got a reply without a granted read");

    holerAntwort: assert property (@(posedge DekodierSignal) disable iff (!arstN)
        holerLeseGueltig |-> $past(holerZuteilung))
        else $error("fetcher got a reply without a granted read");

    retireEinzeln: assert property (@(posedge DekodierSignal) disable iff (!arstN)
        retireGueltig |=> !retireGueltig)
        else $error("retire strobe high on two cycles in a row");

    ruheImReset: assert property (@(posedge DekodierSignal)
        !arstN |-> !memAnfrage && !retireGueltig)
        else $error("outputs active during reset");

endmodule

bind speicherArbiter dekoderKernProps arbiterProps0 (
    .DekodierSignal, .arstN, .holerZuteilung(holer.zuteilung), .lsuZuteilung(lsu.zuteilung),
    .holerLeseGueltig(holer.leseGueltig), .lsuLeseGueltig(lsu.leseGueltig),
    .memAnfrage, .memSchreiben, .retireGueltig(1'b0)
);

bind ablaufSteuerung dekoderKernProps steuerungProps0 (
    .DekodierSignal, .arstN, .holerZuteilung(1'b0), .lsuZuteilung(1'b0),
    .holerLeseGueltig(1'b0), .lsuLeseGueltig(1'b0),
    .memAnfrage(1'b0), .memSchreiben(1'b0), .retireGueltig
);

// ==== verif/dekoderKernTb.sv ====
`timescale 1ns/1ps

module dekoderKernTb;

    logic DekodierSignal;
    logic arstN;
    logic neuStart;
    logic memAnfrage;
    logic memSchreiben;
    logic [dekoderPkg::adrBreite-1:0] memAdresse;
    logic [dekoderPkg::wortBreite-1:0] memSchreibDaten;
    logic [dekoderPkg::wortBreite-1:0] memLeseDaten;
    logic memLeseGueltig;
    logic retireGueltig;
    logic [dekoderPkg::adrBreite-1:0] retirePc;

    logic [31:0] speicher [1024];
    logic [31:0] refSpeicher [1024];
    logic [31:0] regs [64];
    logic [15:0] sollRetire [$];
    logic [15:0] sollAdresse [$];
    logic [31:0] sollDaten [$];
    int retireIdx;
    int schreibIdx;
    int zyklen;
    int grenze;
    logic laeuft;
    logic fertig;
    logic lesePending;
    logic [31:0] leseWert;
    logic [31:0] zufall;

    taktGeber takt0 (.DekodierSignal, .arstN, .neuStart);

    dekoderKern dut0 (
        .DekodierSignal, .arstN, .memAnfrage, .memSchreiben, .memAdresse, .memSchreibDaten,
        .memLeseDaten, .memLeseGueltig, .retireGueltig, .retirePc
    );

    task automatic abbrechen(string grund);
        $display("%s", grund);
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    task automatic pruefeWert(string name, logic [31:0] ist, logic [31:0] soll);
        if (ist !== soll) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, ist, soll);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] naechsteZufall();
        zufall ^= zufall << 13;
        zufall ^= zufall >> 17;
        zufall ^= zufall << 5;
        return zufall;
    endfunction

    function automatic logic [31:0] codeI(logic [5:0] op, int rt, int rs, int imm);
        return {op, rt[4:0], rs[4:0], imm[15:0]};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference executor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic void referenzAusfuehren();
        logic [31:0] w;
        logic [15:0] pc;
        logic [15:0] adr;
        logic [5:0] op;
        logic [4:0] rt;
        logic [4:0] rs;
        pc = '0;
        refSpeicher = speicher;
        foreach (regs[i]) regs[i] = '0;
        sollRetire.delete();
        sollAdresse.delete();
        sollDaten.delete();
        for (int schritt = 0; schritt < 5000; schritt++) begin
            w = refSpeicher[pc[9:0]];
            op = w[31:26];
            rt = w[25:21];
            rs = w[20:16];
            adr = regs[{1'b0, rs}][15:0] + w[15:0];
            sollRetire.push_back(pc);
            if (op == dekoderPkg::opSprungRel && w[15:0] == 16'h0) begin
                return;
            end
            case (op)
                dekoderPkg::opLadeInt: regs[{1'b0, rt}] = refSpeicher[adr[9:0]];
                dekoderPkg::opLadeFloat: regs[{1'b1, rt}] = refSpeicher[adr[9:0]];
                dekoderPkg::opSpeichere: begin
                    refSpeicher[adr[9:0]] = regs[{1'b0, rt}];
                    sollAdresse.push_back(adr);
                    sollDaten.push_back(regs[{1'b0, rt}]);
                end
                dekoderPkg::opJal: regs[{1'b0, rt}] = {16'h0, pc + 16'd1};
                default: ;
            endcase
            if (op == dekoderPkg::opSprungAbs) begin
                pc = w[15:0];
            end else if (op == dekoderPkg::opJal || op == dekoderPkg::opSprungRel
                || (op == dekoderPkg::opSprungBed && regs[{1'b0, rs}] != '0)) begin
                pc = pc + w[15:0];
            end else begin
                pc = pc + 16'd1;
            end
        end
        $display("reference program never reaches its final self-jump");
        $display("Test failed");
        $fatal(1, "run aborted");
    endfunction

    // fill value depends on the whole address.
    task automatic fuelleSpeicher();
        for (int a = 0; a < 1024; a++) begin
            speicher[a] = (32'(a) * 32'h0001_0193) ^ 32'h5A5A_0000 ^ 32'(a);
        end
    endtask

    task automatic ladeGerichtet();
        fuelleSpeicher();
        speicher[10'h200] = 32'h1111_1111;
        speicher[10'h201] = 32'h2222_2222;
        speicher[10'h202] = 32'h0000_0250;
        speicher[0] = codeI(dekoderPkg::opLadeInt, 1, 0, 'h200);
        // same index 1, but in the float bank.
        speicher[1] = codeI(dekoderPkg::opLadeFloat, 1, 0, 'h201);
        speicher[2] = codeI(dekoderPkg::opSpeichere, 1, 0, 'h300);
        speicher[3] = codeI(dekoderPkg::opLadeInt, 2, 0, 'h202);
        speicher[4] = codeI(dekoderPkg::opSpeichere, 1, 2, -16);
        speicher[5] = codeI(dekoderPkg::opLadeInt, 3, 2, -2);
        speicher[6] = codeI(dekoderPkg::opSpeichere, 3, 0, 'h301);
        speicher[7] = codeI(dekoderPkg::opSprungBed, 0, 0, 5);
        speicher[8] = codeI(dekoderPkg::opSprungBed, 0, 2, 2);
        speicher[9] = codeI(dekoderPkg::opSpeichere, 1, 0, 'h302);
        speicher[10] = codeI(dekoderPkg::opJal, 4, 0, 3);
        speicher[11] = codeI(dekoderPkg::opSpeichere, 2, 0, 'h303);
        speicher[12] = codeI(dekoderPkg::opSpeichere, 2, 0, 'h304);
        speicher[13] = codeI(dekoderPkg::opSpeichere, 4, 0, 'h305);
        speicher[14] = 32'h0022_1820;
        speicher[15] = codeI(6'b100000, 1, 1, 5);
        speicher[16] = codeI(dekoderPkg::opSprungAbs, 0, 0, 20);
        for (int a = 17; a < 20; a++) begin
            speicher[a] = codeI(dekoderPkg::opSpeichere, 1, 0, 'h306);
        end
        speicher[20] = codeI(dekoderPkg::opSpeichere, 3, 0, 'h307);
        speicher[21] = {dekoderPkg::opSprungRel, 26'h0};
    endtask

    // forward-only, so every program reaches word 199.
    task automatic erzeugeZufall();
        logic [31:0] r;
        int off;
        fuelleSpeicher();
        for (int pc = 0; pc < 199; pc++) begin
            r = naechsteZufall();
            off = 1 + int'(r[13:12]);
            if (pc + off > 199) begin
                off = 199 - pc;
            end
            case (r[2:0])
                3'd0, 3'd1: speicher[pc] = codeI(dekoderPkg::opLadeInt,
                    int'(r[10:8]) % 7 + 1, 0, 512 + int'(r[24:16]));
                3'd2: speicher[pc] = codeI(dekoderPkg::opLadeFloat, r[12:8], 0,
                    512 + int'(r[24:16]));
                3'd3, 3'd4: speicher[pc] = codeI(dekoderPkg::opSpeichere, r[10:8], 0,
                    512 + int'(r[24:16]));
                3'd5: speicher[pc] = codeI(dekoderPkg::opSprungBed, 0, r[10:8], off);
                3'd6: speicher[pc] = codeI(dekoderPkg::opJal, int'(r[10:8]) % 7 + 1, 0, off);
                default: speicher[pc] = {6'b000000, r[25:0]};
            endcase
        end
        speicher[199] = {dekoderPkg::opSprungRel, 26'h0};
    endtask

    task automatic programmLaufen();
        retireIdx = 0;
        schreibIdx = 0;
        zyklen = 0;
        fertig = 1'b0;
        grenze = sollRetire.size() * 12 + 16;
        @(posedge arstN);
        laeuft = 1'b1;
        while (!fertig) @(posedge DekodierSignal);
        if (schreibIdx != sollAdresse.size()) begin
            abbrechen("fewer stores reached memory than the reference predicts");
        end
        for (int a = 0; a < 1024; a++) begin
            pruefeWert($sformatf("speicher[%0d]", a), speicher[a], refSpeicher[a]);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge DekodierSignal) begin
        if (!arstN) begin
            lesePending = 1'b0;
            memLeseGueltig = 1'b0;
        end else begin
            memLeseGueltig = lesePending;
            memLeseDaten = leseWert;
            lesePending = memAnfrage && !memSchreiben;
            if (lesePending) begin
                leseWert = speicher[memAdresse[9:0]];
            end
            if (memAnfrage && memSchreiben) begin
                speicher[memAdresse[9:0]] = memSchreibDaten;
            end
        end
    end

    // compares retires and stores against the reference.
    always @(negedge DekodierSignal) begin
        if (laeuft && arstN) begin
            if (memAnfrage && memSchreiben) begin
                if (schreibIdx >= sollAdresse.size()) begin
                    abbrechen("store seen at the memory port that the reference does not make");
                end
                pruefeWert("memAdresse", 32'(memAdresse), 32'(sollAdresse[schreibIdx]));
                pruefeWert("memSchreibDaten", memSchreibDaten, sollDaten[schreibIdx]);
                schreibIdx++;
            end
            if (retireGueltig) begin
                pruefeWert("retirePc", 32'(retirePc), 32'(sollRetire[retireIdx]));
                retireIdx++;
                if (retireIdx == sollRetire.size()) begin
                    fertig = 1'b1;
                    laeuft = 1'b0;
                end
            end
        end
    end

    always @(posedge DekodierSignal) begin
        if (laeuft) begin
            zyklen++;
            if (zyklen > grenze) begin
                abbrechen($sformatf("timeout after %0d cycles without the final retire", grenze));
            end
        end
    end

    initial begin
        neuStart = 1'b0;
        memLeseGueltig = 1'b0;
        memLeseDaten = '0;
        laeuft = 1'b0;
        fertig = 1'b0;
        lesePending = 1'b0;
        leseWert = '0;
        zufall = 32'd93279;
        ladeGerichtet();
        referenzAusfuehren();
        programmLaufen();
        @(posedge DekodierSignal);
        neuStart = 1'b1;
        @(negedge arstN);
        neuStart = 1'b0;
        erzeugeZufall();
        referenzAusfuehren();
        programmLaufen();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== filelist.f ====
hw/dekoderPkg.sv
hw/memAnfrageIf.sv
hw/instruktionsDekodierer.sv
hw/befehlsHoler.sv
hw/ladeSpeicherEinheit.sv
hw/speicherArbiter.sv
hw/registerBank.sv
hw/ablaufSteuerung.sv
hw/dekoderKern.sv
verif/taktGeber.sv
verif/dekoderKern_props.sv
verif/dekoderKernTb.sv

// ==== Makefile ====
SIM := obj_dir/VdekoderKernTb
SRCS := $(wildcard hw/*.sv verif/*.sv)

.PHONY: run clean

run: $(SIM)
	./$(SIM)

$(SIM): filelist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module dekoderKernTb -o VdekoderKernTb

clean:
	rm -rf obj_dir
